// File: logic/cpu_fetch_defines.svh
`ifndef CPU_FETCH_DEFINES_SVH
`define CPU_FETCH_DEFINES_SVH

// Program counter value after reset
`define CPU_RESET_PC 32'h0000_0000

// Direct-mapped cache size in lines, one word per line
// Must stay a power of two
`define CPU_ICACHE_LINES 16

// Data and address width of the core
`define CPU_XLEN 32

`endif

// File: logic/cpu_fetch_pkg.sv
`include "cpu_fetch_defines.svh"

`default_nettype none

package cpu_fetch_pkg;

	// Address or instruction word
	typedef logic [`CPU_XLEN-1:0] word_t;

	// Control-flow class of a fetched instruction
	// Anything other than sequential parks fetch until a jump arrives
	typedef enum logic [2:0] {
		CLASS_SEQUENTIAL,
		CLASS_JUMP,
		CLASS_BRANCH,
		CLASS_TRAP,
		CLASS_RETURN,
		CLASS_WAIT
	} instr_class_t;

	// Fetch FSM states
	typedef enum logic {
		WAIT_ICACHE,
		WAIT_JUMP
	} fetch_state_t;

	// Record handed to decode
	// Tag counts records modulo 256, a changed tag marks a new record
	typedef struct packed {
		logic [7:0] tag;
		word_t pc;
		word_t instruction;
		instr_class_t iclass;
	} fetch_data_t;

endpackage

`default_nettype wire

// File: logic/cpu_instr_classify.sv
`default_nettype none
`timescale 1ns/100ps

module cpu_instr_classify (
	input wire cpu_fetch_pkg::word_t i_instruction,
	output cpu_fetch_pkg::instr_class_t o_class
);
	import cpu_fetch_pkg::*;

	// Major opcodes that affect control flow
	localparam logic [6:0] OPCODE_JAL = 7'b1101111;
	localparam logic [6:0] OPCODE_JALR = 7'b1100111;
	localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

	// funct12 of the privileged SYSTEM instructions
	localparam logic [11:0] FUNCT12_ECALL = 12'h000;
	localparam logic [11:0] FUNCT12_MRET = 12'h302;
	localparam logic [11:0] FUNCT12_WFI = 12'h105;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [11:0] funct12;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign funct12 = i_instruction[31:20];

	always_comb begin
		o_class = CLASS_SEQUENTIAL;
		case (opcode)
			OPCODE_JAL, OPCODE_JALR: o_class = CLASS_JUMP;
			OPCODE_BRANCH: o_class = CLASS_BRANCH;
			OPCODE_SYSTEM: begin
				// CSR accesses have nonzero funct3 and fall through as sequential
				if (funct3 == 3'b000) begin
					case (funct12)
						FUNCT12_ECALL: o_class = CLASS_TRAP;
						FUNCT12_MRET: o_class = CLASS_RETURN;
						FUNCT12_WFI: o_class = CLASS_WAIT;
						default: o_class = CLASS_SEQUENTIAL;
					endcase
				end
			end
			default: o_class = CLASS_SEQUENTIAL;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/cpu_icache.sv
`include "cpu_fetch_defines.svh"

`default_nettype none
`timescale 1ns/100ps

module cpu_icache (
	input wire logic i_clock,
	input wire logic i_reset,

	// Lookup from fetch
	input wire cpu_fetch_pkg::word_t i_pc,
	input wire logic i_stall,
	output cpu_fetch_pkg::word_t o_rdata,
	output logic o_ready,

	// Word bus
	output logic o_bus_request,
	output cpu_fetch_pkg::word_t o_bus_address,
	input wire logic i_bus_ready,
	input wire cpu_fetch_pkg::word_t i_bus_rdata
);
	import cpu_fetch_pkg::*;

	localparam int LINES = `CPU_ICACHE_LINES;
	localparam int INDEX_W = $clog2(LINES);
	localparam int ADDR_W = $bits(word_t);
	localparam int TAG_W = ADDR_W - INDEX_W - 2;

	logic [LINES-1:0] valid;
	logic [TAG_W-1:0] tag_mem [LINES];
	word_t data_mem [LINES];

	logic [INDEX_W-1:0] lookup_index;
	logic [TAG_W-1:0] lookup_tag;
	logic hit;
	logic miss_start;

	// Refill word waits one cycle here before the line write
	logic fill_pending;
	word_t fill_data;
	logic [INDEX_W-1:0] fill_index;
	logic [TAG_W-1:0] fill_tag;

	assign lookup_index = i_pc[INDEX_W+1:2];
	assign lookup_tag = i_pc[ADDR_W-1:INDEX_W+2];
	assign fill_index = o_bus_address[INDEX_W+1:2];
	assign fill_tag = o_bus_address[ADDR_W-1:INDEX_W+2];

	always_comb begin
		hit = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
		o_ready = hit && !i_stall;
		o_rdata = data_mem[lookup_index];
	end

	// New refill only when the bus and the write slot are both idle
	assign miss_start = !hit && !o_bus_request && !fill_pending;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bus_request <= 1'b0;
			fill_pending <= 1'b0;
		end
		else begin
			fill_pending <= 1'b0;
			if (o_bus_request) begin
				// Request falls the cycle after the ready pulse
				if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					fill_pending <= 1'b1;
				end
			end
			else if (miss_start) begin
				o_bus_request <= 1'b1;
			end
		end
	end

	// Miss address stays stable for the whole request
	always_ff @(posedge i_clock) begin
		if (miss_start)
			o_bus_address <= {i_pc[ADDR_W-1:2], 2'b00};
		if (o_bus_request && i_bus_ready)
			fill_data <= i_bus_rdata;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset)
			valid <= '0;
		else if (fill_pending)
			valid[fill_index] <= 1'b1;
	end

	always_ff @(posedge i_clock) begin
		if (fill_pending) begin
			tag_mem[fill_index] <= fill_tag;
			data_mem[fill_index] <= fill_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_fetch.sv
`include "cpu_fetch_defines.svh"

`default_nettype none
`timescale 1ns/100ps

module cpu_fetch (
	input wire logic i_clock,
	input wire logic i_reset,

	// Jump command from execute
	input wire logic i_jump,
	input wire cpu_fetch_pkg::word_t i_jump_pc,

	// Interrupt dispatch
	input wire logic i_irq_pending,
	input wire cpu_fetch_pkg::word_t i_irq_pc,
	output logic o_irq_dispatched,
	output cpu_fetch_pkg::word_t o_irq_epc,

	// Word bus
	output logic o_bus_request,
	output cpu_fetch_pkg::word_t o_bus_address,
	input wire logic i_bus_ready,
	input wire cpu_fetch_pkg::word_t i_bus_rdata,

	// Decode side
	input wire logic i_decode_busy,
	output cpu_fetch_pkg::fetch_data_t o_data
);
	import cpu_fetch_pkg::*;

	fetch_state_t state;
	word_t pc;
	fetch_data_t data_current;
	fetch_data_t data_hold;

	word_t icache_rdata;
	logic icache_ready;
	logic icache_stall;
	instr_class_t instr_class;

	// No lookups while decode is busy or while parked on a jump
	assign icache_stall = i_decode_busy || (state != WAIT_ICACHE);

	cpu_icache cpu_icache_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.i_stall(icache_stall),
		.o_rdata(icache_rdata),
		.o_ready(icache_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	cpu_instr_classify cpu_instr_classify_inst (
		.i_instruction(icache_rdata),
		.o_class(instr_class)
	);

	// Hold buffer trails the fetch register by one accepted cycle
	assign o_data = i_decode_busy ? data_hold : data_current;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			data_hold <= '0;
		else if (!i_decode_busy)
			data_hold <= data_current;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= WAIT_ICACHE;
			pc <= `CPU_RESET_PC;
			data_current <= '0;
			o_irq_dispatched <= 1'b0;
		end
		else begin
			o_irq_dispatched <= 1'b0;
			// Interrupt wins over hits and jumps
			if (i_irq_pending) begin
				o_irq_dispatched <= 1'b1;
				o_irq_epc <= pc;
				pc <= i_irq_pc;
				state <= WAIT_ICACHE;
			end
			else begin
				case (state)
					WAIT_ICACHE: begin
						if (icache_ready) begin
							data_current.tag <= data_current.tag + 8'd1;
							data_current.pc <= pc;
							data_current.instruction <= icache_rdata;
							data_current.iclass <= instr_class;
							// pc stays on the control-flow instruction
							if (instr_class != CLASS_SEQUENTIAL)
								state <= WAIT_JUMP;
							else
								pc <= pc + 32'd4;
						end
					end
					WAIT_JUMP: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= WAIT_ICACHE;
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_fetch_top.sv
`default_nettype none
`timescale 1ns/100ps

module cpu_fetch_top (
	input wire logic i_clock,
	input wire logic i_reset,

	input wire logic i_jump,
	input wire cpu_fetch_pkg::word_t i_jump_pc,

	input wire logic i_irq_pending,
	input wire cpu_fetch_pkg::word_t i_irq_pc,
	output logic o_irq_dispatched,
	output cpu_fetch_pkg::word_t o_irq_epc,

	output logic o_bus_request,
	output cpu_fetch_pkg::word_t o_bus_address,
	input wire logic i_bus_ready,
	input wire cpu_fetch_pkg::word_t i_bus_rdata,

	input wire logic i_decode_busy,
	output cpu_fetch_pkg::fetch_data_t o_data
);

	// Fetch stage with its cache and classifier
	cpu_fetch cpu_fetch_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.i_decode_busy(i_decode_busy),
		.o_data(o_data)
	);

endmodule

`default_nettype wire

// File: verif/tb_cpu_fetch_top.sv
`include "cpu_fetch_defines.svh"

`default_nettype none
`timescale 1ns/100ps

module tb_cpu_fetch_top;
	import cpu_fetch_pkg::*;

	localparam int MEM_WORDS = 64;
	localparam int ROUNDS = 60;
	localparam int TIMEOUT = 2000;

	logic clock;
	logic reset;
	logic jump;
	word_t jump_pc;
	logic irq_pending;
	word_t irq_pc;
	logic irq_dispatched;
	word_t irq_epc;
	logic bus_request;
	word_t bus_address;
	logic bus_ready;
	word_t bus_rdata;
	logic decode_busy;
	fetch_data_t data;

	word_t mem [MEM_WORDS];
	logic [31:0] lfsr_state;

	// Reference model of the fetch stage
	word_t exp_pc;
	logic [7:0] exp_tag;
	logic parked;
	fetch_data_t prev_data;
	int irqs;

	// Bus memory and control request state
	logic bus_active;
	word_t bus_held_address;
	int bus_delay;
	logic irq_active;
	word_t irq_target;
	logic jump_next;
	word_t jump_target;
	logic dispatch_seen;
	word_t dispatch_epc;

	cpu_fetch_top cpu_fetch_top_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.i_irq_pending(irq_pending),
		.i_irq_pc(irq_pc),
		.o_irq_dispatched(irq_dispatched),
		.o_irq_epc(irq_epc),
		.o_bus_request(bus_request),
		.o_bus_address(bus_address),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata),
		.i_decode_busy(decode_busy),
		.o_data(data)
	);

	always #4 clock = ~clock;

	// Taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] bits;
		logic feedback;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			bits = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	function automatic instr_class_t expected_class(input word_t instr);
		if (instr[6:0] == 7'h6f || instr[6:0] == 7'h67)
			return CLASS_JUMP;
		if (instr[6:0] == 7'h63)
			return CLASS_BRANCH;
		// Only SYSTEM words with funct3 zero can be privileged
		// CSR ops run on
		if (instr[6:0] == 7'h73 && instr[14:12] == 3'b000) begin
			if (instr[31:20] == 12'h000)
				return CLASS_TRAP;
			if (instr[31:20] == 12'h302)
				return CLASS_RETURN;
			if (instr[31:20] == 12'h105)
				return CLASS_WAIT;
		end
		return CLASS_SEQUENTIAL;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_record(input fetch_data_t actual, input fetch_data_t expected,
			input string what);
		if (actual !== expected)
			stop_with_error($sformatf(
				"Mismatch at %0t: %s, got tag %0d pc %h instr %h class %0d, %s %0d %h %h %0d",
				$time, what, actual.tag, actual.pc, actual.instruction, actual.iclass,
				"expected", expected.tag, expected.pc, expected.instruction, expected.iclass));
	endtask

	task automatic check_epc(input word_t actual, input word_t expected, input string what);
		if (actual !== expected)
			stop_with_error($sformatf("Mismatch at %0t: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic fill_memory();
		word_t word;
		for (int i = 0; i < MEM_WORDS; i++) begin
			word = lfsr_bits(32);
			// Roughly one word in five gets a control-flow encoding
			if (lfsr_bits(4) < 3) begin
				case (lfsr_bits(3) % 6)
					0: word = 32'h0080_006f;
					1: word = 32'h0000_8067;
					2: word = 32'h0020_8463;
					3: word = 32'h0000_0073;
					4: word = 32'h3020_0073;
					default: word = 32'h1050_0073;
				endcase
			end
			mem[i] = word;
		end
	endtask

	// Addresses wrap over the 64 words
	task automatic respond_bus();
		if (bus_ready) begin
			bus_ready = 1'b0;
		end
		else if (bus_request) begin
			if (!bus_active) begin
				bus_active = 1'b1;
				bus_held_address = bus_address;
				bus_delay = 1 + lfsr_bits(2);
			end
			else if (bus_address !== bus_held_address)
				stop_with_error("Bus address changed while the request was held");
			bus_delay--;
			if (bus_delay == 0) begin
				bus_ready = 1'b1;
				bus_rdata = mem[bus_address[7:2]];
				bus_active = 1'b0;
			end
		end
	endtask

	task automatic take_record();
		fetch_data_t expected;
		if (parked)
			stop_with_error("A new record appeared while fetch waited for a jump");
		expected.tag = exp_tag + 8'd1;
		expected.pc = exp_pc;
		expected.instruction = mem[exp_pc[7:2]];
		expected.iclass = expected_class(expected.instruction);
		check_record(data, expected, "fetched record");
		exp_tag = expected.tag;
		if (expected.iclass == CLASS_SEQUENTIAL)
			exp_pc = exp_pc + 32'd4;
		else
			parked = 1'b1;
	endtask

	// One clock cycle with drives at 1 ns and samples at 3 ns
	task automatic tick();
		@(posedge clock);
		#1;
		if (irq_dispatched) begin
			if (!irq_active)
				stop_with_error("Interrupt dispatched without a pending request");
			irq_active = 1'b0;
			dispatch_seen = 1'b1;
			dispatch_epc = irq_epc;
		end
		respond_bus();
		irq_pending = irq_active;
		irq_pc = irq_target;
		jump = jump_next;
		jump_pc = jump_target;
		jump_next = 1'b0;
		decode_busy = (lfsr_bits(2) == 32'd0);
		#2;
		if (decode_busy)
			check_record(data, prev_data, "record under decode busy");
		else if (data.tag != prev_data.tag)
			take_record();
		prev_data = data;
	endtask

	task automatic run_until_parked();
		int cycles;
		cycles = 0;
		while (!parked) begin
			if (cycles == TIMEOUT)
				stop_with_error("Timed out waiting for a control-flow record");
			tick();
			cycles++;
		end
	endtask

	task automatic give_jump();
		jump_next = 1'b1;
		jump_target = lfsr_bits(6) << 2;
		tick();
		parked = 1'b0;
		exp_pc = jump_target;
	endtask

	task automatic raise_interrupt();
		int cycles;
		irq_target = lfsr_bits(6) << 2;
		irq_active = 1'b1;
		dispatch_seen = 1'b0;
		cycles = 0;
		while (!dispatch_seen) begin
			if (cycles == TIMEOUT)
				stop_with_error("Timed out waiting for the interrupt dispatch");
			tick();
			cycles++;
		end
		// Parked pc is still the control-flow record's address
		check_epc(dispatch_epc, exp_pc, "exception pc");
		parked = 1'b0;
		exp_pc = irq_target;
		irqs++;
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		jump = 1'b0;
		jump_pc = '0;
		irq_pending = 1'b0;
		irq_pc = '0;
		bus_ready = 1'b0;
		bus_rdata = '0;
		decode_busy = 1'b0;
		lfsr_state = 32'd80076;
		exp_pc = `CPU_RESET_PC;
		exp_tag = 8'd0;
		parked = 1'b0;
		irqs = 0;
		bus_active = 1'b0;
		bus_held_address = '0;
		bus_delay = 0;
		irq_active = 1'b0;
		irq_target = '0;
		jump_next = 1'b0;
		jump_target = '0;
		dispatch_seen = 1'b0;
		dispatch_epc = '0;
		fill_memory();

		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		check_record(data, '0, "record after reset");
		if (bus_request !== 1'b0 || irq_dispatched !== 1'b0)
			stop_with_error("Bus request or dispatch was active right after reset");
		prev_data = data;

		for (int round = 0; round < ROUNDS; round++) begin
			run_until_parked();
			repeat (lfsr_bits(3)) tick();
			if (lfsr_bits(2) == 32'd0)
				raise_interrupt();
			else
				give_jump();
		end

		if (irqs == 0)
			stop_with_error("Run ended without any interrupt dispatch");
		else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/cpu_fetch_pkg.sv
logic/cpu_instr_classify.sv
logic/cpu_icache.sv
logic/cpu_fetch.sv
logic/cpu_fetch_top.sv
verif/tb_cpu_fetch_top.sv

// File: Bender.yml
package:
  name: cpu_fetch

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_fetch_pkg.sv
      - logic/cpu_instr_classify.sv
      - logic/cpu_icache.sv
      - logic/cpu_fetch.sv
      - logic/cpu_fetch_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_cpu_fetch_top.sv
